// ==== list.f ====
verilog/core_pkg.sv
verilog/axil_settings_slave.sv
verilog/misc_settings.sv
verilog/vita_timer.sv
verilog/irq_ctrl.sv
verilog/core_top.sv
test/core_tb.sv

// ==== test/core_trace.txt ====
# W addr data | R addr expected | S input value | O output expected | P cycles | N cycles
# T hi lo: time not below hi:lo | D: PPS capture delta check. Values in hex, cycles decimal
O clock_outs 0
O serdes_outs 0
O adc_outs 0
O phy_reset_n 1
O leds 0
O irq 0
R 030 00000005
R 000 00000000
# Misc setting registers
W 000 0000001B
O clock_outs 1B
W 004 0000000A
O serdes_outs A
W 008 00000005
O adc_outs 5
W 010 00000001
O phy_reset_n 0
W 014 FFFFFFFF
W 3FC 12345678
O clock_outs 1B
O serdes_outs A
O adc_outs 5
O phy_reset_n 0
W 010 00000000
O phy_reset_n 1
# LEDs, hardware owns 1 to 4 after reset
S run_tx 1
S clk_status 1
O leds 14
S serdes_link 1
W 00C 000000A5
W 020 0000000F
O leds A6
S sim_mode 1
S clock_divider 9
R 024 80000009
# VITA time load
W 300 00000012
W 304 00001000
T 00000012 00001000
T 00000012 00001000
# PPS capture
P 3
N 12
D
P 4
N 20
D
# Interrupts
S clk_status 0
N 5
W 324 000000FF
R 020 00000000
W 320 00000002
S clk_status 1
N 6
R 020 00000002
R 034 00000006
O irq 1
W 324 00000002
N 2
R 020 00000000
O irq 0
W 320 00000000
S clk_status 0
N 5
S clk_status 1
N 6
R 020 00000002
O irq 0

// ==== test/core_tb.sv ====
// Radio core control testbench
// Runs the operation trace against core_top over AXI4-Lite with random stalls

module core_tb;

   typedef logic [8*16-1:0] name_t;

   localparam int WATCHDOG_CYCLES_PER_LINE = 50;

   logic        dsp_clk;
   logic        rst_n_i;
   logic [11:0] awaddr;
   logic        awvalid;
   logic        awready;
   logic [31:0] wdata;
   logic        wvalid;
   logic        wready;
   logic [1:0]  bresp;
   logic        bvalid;
   logic        bready;
   logic [11:0] araddr;
   logic        arvalid;
   logic        arready;
   logic [31:0] rdata;
   logic [1:0]  rresp;
   logic        rvalid;
   logic        rready;
   logic        pps;
   logic        clk_status;
   logic        serdes_link;
   logic        phy_int_n;
   logic        run_rx;
   logic        run_tx;
   logic        sim_mode;
   logic [3:0]  clock_divider;
   logic [1:0]  clk_en;
   logic [1:0]  clk_sel;
   logic        clock_ready;
   logic        ser_enable;
   logic        ser_prbsen;
   logic        ser_loopen;
   logic        ser_rx_en;
   logic        adc_on_a;
   logic        adc_oe_a;
   logic        adc_on_b;
   logic        adc_oe_b;
   logic        phy_reset_n;
   logic [7:0]  leds;
   logic        irq;

   int          errors = 0;
   int          checks = 0;
   int          trace_lines = 0;
   int          line_no = 0;
   longint      cycle_count = 0;
   longint      last_edge_cycle = 0;
   longint      prev_edge_cycle = 0;
   logic [63:0] prev_cap = '0;
   bit          have_cap = 1'b0;
   logic [63:0] last_time = '0;

   core_top uut (
      .dsp_clk          (dsp_clk),
      .rst_n_i          (rst_n_i),
      .s_axil_awaddr_i  (awaddr),
      .s_axil_awvalid_i (awvalid),
      .s_axil_awready_o (awready),
      .s_axil_wdata_i   (wdata),
      .s_axil_wvalid_i  (wvalid),
      .s_axil_wready_o  (wready),
      .s_axil_bresp_o   (bresp),
      .s_axil_bvalid_o  (bvalid),
      .s_axil_bready_i  (bready),
      .s_axil_araddr_i  (araddr),
      .s_axil_arvalid_i (arvalid),
      .s_axil_arready_o (arready),
      .s_axil_rdata_o   (rdata),
      .s_axil_rresp_o   (rresp),
      .s_axil_rvalid_o  (rvalid),
      .s_axil_rready_i  (rready),
      .pps_i            (pps),
      .clk_status_i     (clk_status),
      .serdes_link_i    (serdes_link),
      .phy_int_n_i      (phy_int_n),
      .run_rx_i         (run_rx),
      .run_tx_i         (run_tx),
      .sim_mode_i       (sim_mode),
      .clock_divider_i  (clock_divider),
      .clk_en_o         (clk_en),
      .clk_sel_o        (clk_sel),
      .clock_ready_o    (clock_ready),
      .ser_enable_o     (ser_enable),
      .ser_prbsen_o     (ser_prbsen),
      .ser_loopen_o     (ser_loopen),
      .ser_rx_en_o      (ser_rx_en),
      .adc_on_a_o       (adc_on_a),
      .adc_oe_a_o       (adc_oe_a),
      .adc_on_b_o       (adc_on_b),
      .adc_oe_b_o       (adc_oe_b),
      .phy_reset_n_o    (phy_reset_n),
      .leds_o           (leds),
      .irq_o            (irq)
   );

   initial dsp_clk = 1'b0;
   always #10 dsp_clk = ~dsp_clk;

   always @(posedge dsp_clk) cycle_count <= cycle_count + 1;

   ////////////////////
   // Helpers

   task automatic check_value(input name_t name, input logic [63:0] got,
                              input logic [63:0] expected);
      checks++;
      if (got !== expected) begin
         errors++;
         $display("** Error: %0s = 0x%0h, expected 0x%0h (trace line %0d, time %0t)",
                  name, got, expected, line_no, $time);
      end
   endtask

   // Inputs change 2 units after the rising edge
   task automatic next_cycle;
      @(posedge dsp_clk);
      #2;
   endtask

   task automatic axi_write(input logic [11:0] addr, input logic [31:0] data);
      bit done;
      awaddr  = addr;
      awvalid = 1'b1;
      wdata   = data;
      wvalid  = 1'b1;
      do begin
         @(negedge dsp_clk);
      end while (!(awready && wready));
      next_cycle();
      awvalid = 1'b0;
      wvalid  = 1'b0;
      done    = 1'b0;
      // Random back-pressure on the response
      while (!done) begin
         bready = ($urandom % 4) != 0;
         @(negedge dsp_clk);
         if (bvalid && bready) begin
            check_value("bresp", bresp, 64'd0);
            done = 1'b1;
         end
         next_cycle();
      end
      bready = 1'b0;
   endtask

   task automatic axi_read(input logic [11:0] addr, output logic [31:0] data);
      bit done;
      araddr  = addr;
      arvalid = 1'b1;
      do begin
         @(negedge dsp_clk);
      end while (!arready);
      next_cycle();
      arvalid = 1'b0;
      done    = 1'b0;
      data    = '0;
      while (!done) begin
         rready = ($urandom % 4) != 0;
         @(negedge dsp_clk);
         if (rvalid && rready) begin
            data = rdata;
            check_value("rresp", rresp, 64'd0);
            done = 1'b1;
         end
         next_cycle();
      end
      rready = 1'b0;
   endtask

   task automatic set_input(input name_t name, input logic [31:0] value);
      case (name)
         "clk_status":    clk_status    = value[0];
         "serdes_link":   serdes_link   = value[0];
         "phy_int_n":     phy_int_n     = value[0];
         "run_rx":        run_rx        = value[0];
         "run_tx":        run_tx        = value[0];
         "sim_mode":      sim_mode      = value[0];
         "clock_divider": clock_divider = value[3:0];
         default: begin
            errors++;
            $display("Trace line %0d names an unknown status input %0s", line_no, name);
         end
      endcase
   endtask

   // Output groups in the bit order of the setting registers
   task automatic sample_output(input name_t name, output logic [31:0] value,
                                output bit known);
      known = 1'b1;
      case (name)
         "clock_outs":  value = {27'd0, clock_ready, clk_en, clk_sel};
         "serdes_outs": value = {28'd0, ser_enable, ser_prbsen, ser_loopen, ser_rx_en};
         "adc_outs":    value = {28'd0, adc_oe_a, adc_on_a, adc_oe_b, adc_on_b};
         "phy_reset_n": value = {31'd0, phy_reset_n};
         "leds":        value = {24'd0, leds};
         "irq":         value = {31'd0, irq};
         default: begin
            value = '0;
            known = 1'b0;
         end
      endcase
   endtask

   task automatic pulse_pps(input int unsigned cycles);
      pps             = 1'b1;
      last_edge_cycle = cycle_count;
      repeat (cycles) next_cycle();
      pps = 1'b0;
   endtask

   // Time must not be earlier than the load or the previous read
   task automatic check_time_load(input logic [31:0] exp_hi, input logic [31:0] exp_lo);
      logic [31:0] hi;
      logic [31:0] lo;
      logic [63:0] now;
      axi_read(12'h028, hi);
      axi_read(12'h02C, lo);
      now    = {hi, lo};
      checks = checks + 2;
      if (now < {exp_hi, exp_lo}) begin
         errors++;
         $display("** Error: time = 0x%0h is earlier than the loaded 0x%0h (trace line %0d)",
                  now, {exp_hi, exp_lo}, line_no);
      end
      if (now < last_time) begin
         errors++;
         $display("** Error: time = 0x%0h is earlier than the last read 0x%0h (trace line %0d)",
                  now, last_time, line_no);
      end
      last_time = now;
   endtask

   // Capture difference against the cycles between the driven PPS edges
   task automatic check_pps_delta;
      logic [31:0] hi;
      logic [31:0] lo;
      logic [63:0] cap;
      axi_read(12'h038, hi);
      axi_read(12'h03C, lo);
      cap = {hi, lo};
      if (have_cap) begin
         check_value("pps_time_delta", cap - prev_cap, last_edge_cycle - prev_edge_cycle);
      end
      prev_cap        = cap;
      prev_edge_cycle = last_edge_cycle;
      have_cap        = 1'b1;
   endtask

   task automatic apply_reset;
      rst_n_i = 1'b0;
      repeat (9) @(posedge dsp_clk);
      @(negedge dsp_clk);
      check_value("awready", awready, 64'd0);
      check_value("wready", wready, 64'd0);
      check_value("arready", arready, 64'd0);
      check_value("bvalid", bvalid, 64'd0);
      check_value("rvalid", rvalid, 64'd0);
      check_value("irq", irq, 64'd0);
      check_value("phy_reset_n", phy_reset_n, 64'd1);
      next_cycle();
      rst_n_i = 1'b1;
   endtask

   ////////////////////
   // Trace runner

   task automatic run_trace(input int fd);
      logic [8*128-1:0] line;
      logic [63:0]      op;
      name_t            name;
      logic [31:0]      arg_a;
      logic [31:0]      arg_b;
      logic [31:0]      got;
      bit               known;
      int               code;
      while ($fgets(line, fd) != 0) begin
         line_no++;
         op   = '0;
         code = $sscanf(line, "%s", op);
         if (code >= 1 && op != "#") begin
            case (op)
               "W": begin
                  code = $sscanf(line, "%s %h %h", op, arg_a, arg_b);
                  axi_write(arg_a[11:0], arg_b);
               end
               "R": begin
                  code = $sscanf(line, "%s %h %h", op, arg_a, arg_b);
                  axi_read(arg_a[11:0], got);
                  check_value("rdata", got, arg_b);
               end
               "S": begin
                  code = $sscanf(line, "%s %s %h", op, name, arg_a);
                  set_input(name, arg_a);
               end
               "O": begin
                  code = $sscanf(line, "%s %s %h", op, name, arg_a);
                  @(negedge dsp_clk);
                  sample_output(name, got, known);
                  if (known) begin
                     check_value(name, got, arg_a);
                  end else begin
                     errors++;
                     $display("Trace line %0d names an unknown output %0s", line_no, name);
                  end
                  next_cycle();
               end
               "P": begin
                  code = $sscanf(line, "%s %d", op, arg_a);
                  pulse_pps(arg_a);
               end
               "N": begin
                  code = $sscanf(line, "%s %d", op, arg_a);
                  repeat (arg_a) next_cycle();
               end
               "T": begin
                  code = $sscanf(line, "%s %h %h", op, arg_a, arg_b);
                  check_time_load(arg_a, arg_b);
               end
               "D": check_pps_delta();
               default: begin
                  errors++;
                  $display("Trace line %0d has an unknown operation %0s", line_no, op);
               end
            endcase
         end
      end
   endtask

   initial begin : main
      int               fd;
      int unsigned      seed;
      logic [8*128-1:0] line;
      awaddr        = '0;
      awvalid       = 1'b0;
      wdata         = '0;
      wvalid        = 1'b0;
      bready        = 1'b0;
      araddr        = '0;
      arvalid       = 1'b0;
      rready        = 1'b0;
      pps           = 1'b0;
      clk_status    = 1'b0;
      serdes_link   = 1'b0;
      phy_int_n     = 1'b1;
      run_rx        = 1'b0;
      run_tx        = 1'b0;
      sim_mode      = 1'b0;
      clock_divider = '0;
      rst_n_i       = 1'b0;
      seed          = $urandom(60685);
      fd = $fopen("test/core_trace.txt", "r");
      if (fd == 0) begin
         $display("Could not open the trace file test/core_trace.txt");
         $display("=== FAIL ===");
         $finish;
      end else begin
         // Line count sets the watchdog budget
         while ($fgets(line, fd) != 0) begin
            trace_lines++;
         end
         $fclose(fd);
         fd = $fopen("test/core_trace.txt", "r");
         apply_reset();
         run_trace(fd);
         $fclose(fd);
         repeat (4) next_cycle();
         $display("Trace done: %0d checks, %0d errors", checks, errors);
         if (errors == 0) begin
            $display("=== PASS ===");
         end else begin
            $display("=== FAIL ===");
         end
         $finish;
      end
   end

   initial begin : watchdog
      wait (rst_n_i === 1'b1);
      repeat (trace_lines * WATCHDOG_CYCLES_PER_LINE) @(posedge dsp_clk);
      $display("Timed out after %0d cycles with the trace unfinished at line %0d",
               trace_lines * WATCHDOG_CYCLES_PER_LINE, line_no);
      $display("Trace stopped: %0d checks, %0d errors", checks, errors);
      $display("=== FAIL ===");
      $finish;
   end

endmodule

// ==== verilog/core_top.sv ====
// Radio core control top
// AXI4-Lite settings slave, misc registers, VITA timer and interrupt controller

module core_top
   import core_pkg::*;
(
   input  logic                  dsp_clk,
   input  logic                  rst_n_i,
   // AXI4-Lite
   input  logic [AXI_ADDR_W-1:0] s_axil_awaddr_i,
   input  logic                  s_axil_awvalid_i,
   output logic                  s_axil_awready_o,
   input  logic [SET_DATA_W-1:0] s_axil_wdata_i,
   input  logic                  s_axil_wvalid_i,
   output logic                  s_axil_wready_o,
   output logic [1:0]            s_axil_bresp_o,
   output logic                  s_axil_bvalid_o,
   input  logic                  s_axil_bready_i,
   input  logic [AXI_ADDR_W-1:0] s_axil_araddr_i,
   input  logic                  s_axil_arvalid_i,
   output logic                  s_axil_arready_o,
   output logic [SET_DATA_W-1:0] s_axil_rdata_o,
   output logic [1:0]            s_axil_rresp_o,
   output logic                  s_axil_rvalid_o,
   input  logic                  s_axil_rready_i,
   // Status inputs
   input  logic                  pps_i,
   input  logic                  clk_status_i,
   input  logic                  serdes_link_i,
   input  logic                  phy_int_n_i,
   input  logic                  run_rx_i,
   input  logic                  run_tx_i,
   input  logic                  sim_mode_i,
   input  logic [3:0]            clock_divider_i,
   // Control outputs
   output logic [1:0]            clk_en_o,
   output logic [1:0]            clk_sel_o,
   output logic                  clock_ready_o,
   output logic                  ser_enable_o,
   output logic                  ser_prbsen_o,
   output logic                  ser_loopen_o,
   output logic                  ser_rx_en_o,
   output logic                  adc_on_a_o,
   output logic                  adc_oe_a_o,
   output logic                  adc_on_b_o,
   output logic                  adc_oe_b_o,
   output logic                  phy_reset_n_o,
   output logic [7:0]            leds_o,
   output logic                  irq_o
);

   logic                  set_stb;
   logic [SET_ADDR_W-1:0] set_addr;
   logic [SET_DATA_W-1:0] set_data;
   logic [63:0]           vita_time;
   logic [63:0]           vita_time_pps;
   logic                  pps_int;
   logic [NUM_IRQ-1:0]    irq_src;
   logic [NUM_IRQ-1:0]    irq_pend;
   logic [NUM_IRQ-1:0]    irq_raw;
   logic [SET_DATA_W-1:0] status;

   // Status word, sim mode on top and clock divider at the bottom
   assign status = {sim_mode_i, {(SET_DATA_W-5){1'b0}}, clock_divider_i};

   // PHY interrupt pin is active low
   assign irq_src = {{(NUM_IRQ-4){1'b0}}, ~phy_int_n_i, serdes_link_i, clk_status_i, pps_int};

   ////////////////////
   // Settings bus

   axil_settings_slave u_slave (
      .dsp_clk          (dsp_clk),
      .rst_n_i          (rst_n_i),
      .s_axil_awaddr_i  (s_axil_awaddr_i),
      .s_axil_awvalid_i (s_axil_awvalid_i),
      .s_axil_awready_o (s_axil_awready_o),
      .s_axil_wdata_i   (s_axil_wdata_i),
      .s_axil_wvalid_i  (s_axil_wvalid_i),
      .s_axil_wready_o  (s_axil_wready_o),
      .s_axil_bresp_o   (s_axil_bresp_o),
      .s_axil_bvalid_o  (s_axil_bvalid_o),
      .s_axil_bready_i  (s_axil_bready_i),
      .s_axil_araddr_i  (s_axil_araddr_i),
      .s_axil_arvalid_i (s_axil_arvalid_i),
      .s_axil_arready_o (s_axil_arready_o),
      .s_axil_rdata_o   (s_axil_rdata_o),
      .s_axil_rresp_o   (s_axil_rresp_o),
      .s_axil_rvalid_o  (s_axil_rvalid_o),
      .s_axil_rready_i  (s_axil_rready_i),
      .set_stb_o        (set_stb),
      .set_addr_o       (set_addr),
      .set_data_o       (set_data),
      .irq_pend_i       (irq_pend),
      .irq_raw_i        (irq_raw),
      .status_i         (status),
      .time_i           (vita_time),
      .pps_time_i       (vita_time_pps)
   );

   ////////////////////
   // Settings slaves

   misc_settings #(.BASE(SR_MISC)) u_misc (
      .dsp_clk       (dsp_clk),
      .rst_n_i       (rst_n_i),
      .set_stb_i     (set_stb),
      .set_addr_i    (set_addr),
      .set_data_i    (set_data),
      .clk_status_i  (clk_status_i),
      .serdes_link_i (serdes_link_i),
      .run_rx_i      (run_rx_i),
      .run_tx_i      (run_tx_i),
      .clock_outs_o  ({clock_ready_o, clk_en_o, clk_sel_o}),
      .serdes_outs_o ({ser_enable_o, ser_prbsen_o, ser_loopen_o, ser_rx_en_o}),
      .adc_outs_o    ({adc_oe_a_o, adc_on_a_o, adc_oe_b_o, adc_on_b_o}),
      .phy_reset_n_o (phy_reset_n_o),
      .leds_o        (leds_o)
   );

   vita_timer #(.BASE(SR_TIME64)) u_timer (
      .dsp_clk    (dsp_clk),
      .rst_n_i    (rst_n_i),
      .set_stb_i  (set_stb),
      .set_addr_i (set_addr),
      .set_data_i (set_data),
      .pps_i      (pps_i),
      .time_o     (vita_time),
      .pps_time_o (vita_time_pps),
      .pps_int_o  (pps_int)
   );

   irq_ctrl #(.BASE(SR_IRQ)) u_irq (
      .dsp_clk    (dsp_clk),
      .rst_n_i    (rst_n_i),
      .set_stb_i  (set_stb),
      .set_addr_i (set_addr),
      .set_data_i (set_data),
      .irq_src_i  (irq_src),
      .irq_pend_o (irq_pend),
      .irq_raw_o  (irq_raw),
      .irq_o      (irq_o)
   );

endmodule

// ==== verilog/irq_ctrl.sv ====
// Interrupt controller
// Latches rising source edges, masks them, write-one-to-clear through settings

module irq_ctrl
   import core_pkg::*;
#(
   parameter int BASE = SR_IRQ
) (
   input  logic                  dsp_clk,
   input  logic                  rst_n_i,
   input  logic                  set_stb_i,
   input  logic [SET_ADDR_W-1:0] set_addr_i,
   input  logic [SET_DATA_W-1:0] set_data_i,
   input  logic [NUM_IRQ-1:0]    irq_src_i,
   output logic [NUM_IRQ-1:0]    irq_pend_o,
   output logic [NUM_IRQ-1:0]    irq_raw_o,
   output logic                  irq_o
);

   localparam logic [SET_ADDR_W-1:0] A_MASK  = SET_ADDR_W'(BASE);
   localparam logic [SET_ADDR_W-1:0] A_CLEAR = SET_ADDR_W'(BASE + 1);

   logic [NUM_IRQ-1:0] src_s1;
   logic [NUM_IRQ-1:0] src_s2;
   logic [NUM_IRQ-1:0] src_d;
   logic [NUM_IRQ-1:0] rise;
   logic [NUM_IRQ-1:0] clr;
   logic [NUM_IRQ-1:0] mask_q;

   assign rise = src_s2 & ~src_d;
   assign clr  = (set_stb_i && (set_addr_i == A_CLEAR)) ? set_data_i[NUM_IRQ-1:0] : '0;

   assign irq_raw_o = src_s2;

   always_ff @(posedge dsp_clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         src_s1     <= '0;
         src_s2     <= '0;
         src_d      <= '0;
         mask_q     <= '0;
         irq_pend_o <= '0;
         irq_o      <= 1'b0;
      end else begin
         src_s1 <= irq_src_i;
         src_s2 <= src_s1;
         src_d  <= src_s2;
         if (set_stb_i && (set_addr_i == A_MASK)) begin
            mask_q <= set_data_i[NUM_IRQ-1:0];
         end
         // A new edge wins over a clear in the same cycle
         irq_pend_o <= (irq_pend_o & ~clr) | rise;
         irq_o      <= |(irq_pend_o & mask_q);
      end
   end

   a_mask_off: assert property (@(posedge dsp_clk) disable iff (!rst_n_i)
      (mask_q == '0) |=> !irq_o);

endmodule

// ==== verilog/vita_timer.sv ====
// VITA time counter
// Free-running 64-bit time with a two-word software load and PPS capture

module vita_timer
   import core_pkg::*;
#(
   parameter int BASE = SR_TIME64
) (
   input  logic                  dsp_clk,
   input  logic                  rst_n_i,
   input  logic                  set_stb_i,
   input  logic [SET_ADDR_W-1:0] set_addr_i,
   input  logic [SET_DATA_W-1:0] set_data_i,
   input  logic                  pps_i,
   output logic [63:0]           time_o,
   output logic [63:0]           pps_time_o,
   output logic                  pps_int_o
);

   localparam logic [SET_ADDR_W-1:0] A_HI = SET_ADDR_W'(BASE);
   localparam logic [SET_ADDR_W-1:0] A_LO = SET_ADDR_W'(BASE + 1);

   logic [SET_DATA_W-1:0] pend_hi;
   logic                  commit;
   logic                  pps_s1;
   logic                  pps_s2;
   logic                  pps_d;
   logic                  pps_edge;

   // Low word write loads the whole time
   assign commit = set_stb_i && (set_addr_i == A_LO);

   always_ff @(posedge dsp_clk) begin
      if (set_stb_i && (set_addr_i == A_HI)) begin
         pend_hi <= set_data_i;
      end
   end

   ////////////////////
   // Time counter

   always_ff @(posedge dsp_clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         time_o <= '0;
      end else if (commit) begin
         time_o <= {pend_hi, set_data_i};
      end else begin
         time_o <= time_o + 64'd1;
      end
   end

   ////////////////////
   // PPS capture

   // Two-flop sync, then rising edge
   assign pps_edge = pps_s2 & ~pps_d;

   always_ff @(posedge dsp_clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         pps_s1     <= 1'b0;
         pps_s2     <= 1'b0;
         pps_d      <= 1'b0;
         pps_int_o  <= 1'b0;
         pps_time_o <= '0;
      end else begin
         pps_s1    <= pps_i;
         pps_s2    <= pps_s1;
         pps_d     <= pps_s2;
         pps_int_o <= pps_edge;
         if (pps_edge) begin
            pps_time_o <= time_o;
         end
      end
   end

   a_time_step: assert property (@(posedge dsp_clk) disable iff (!rst_n_i)
      !commit |=> time_o == $past(time_o) + 64'd1);

endmodule

// ==== verilog/misc_settings.sv ====
// Miscellaneous setting registers
// Clock, SERDES, ADC and PHY reset control lines plus the LED source mux

module misc_settings
   import core_pkg::*;
#(
   parameter int BASE = SR_MISC
) (
   input  logic                  dsp_clk,
   input  logic                  rst_n_i,
   input  logic                  set_stb_i,
   input  logic [SET_ADDR_W-1:0] set_addr_i,
   input  logic [SET_DATA_W-1:0] set_data_i,
   input  logic                  clk_status_i,
   input  logic                  serdes_link_i,
   input  logic                  run_rx_i,
   input  logic                  run_tx_i,
   output logic [4:0]            clock_outs_o,
   output logic [3:0]            serdes_outs_o,
   output logic [3:0]            adc_outs_o,
   output logic                  phy_reset_n_o,
   output logic [7:0]            leds_o
);

   localparam logic [SET_ADDR_W-1:0] A_CLK     = SET_ADDR_W'(BASE);
   localparam logic [SET_ADDR_W-1:0] A_SERDES  = SET_ADDR_W'(BASE + 1);
   localparam logic [SET_ADDR_W-1:0] A_ADC     = SET_ADDR_W'(BASE + 2);
   localparam logic [SET_ADDR_W-1:0] A_LED_SW  = SET_ADDR_W'(BASE + 3);
   localparam logic [SET_ADDR_W-1:0] A_PHY     = SET_ADDR_W'(BASE + 4);
   localparam logic [SET_ADDR_W-1:0] A_LED_SRC = SET_ADDR_W'(BASE + 8);

   logic       phy_reset;
   logic [7:0] led_sw;
   logic [7:0] led_src;
   logic [7:0] led_hw;

   ////////////////////
   // Setting registers

   always_ff @(posedge dsp_clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         clock_outs_o  <= '0;
         serdes_outs_o <= '0;
         adc_outs_o    <= '0;
         led_sw        <= '0;
         phy_reset     <= 1'b0;
         led_src       <= LED_SRC_RESET;
      end else if (set_stb_i) begin
         case (set_addr_i)
            A_CLK:     clock_outs_o  <= set_data_i[4:0];
            A_SERDES:  serdes_outs_o <= set_data_i[3:0];
            A_ADC:     adc_outs_o    <= set_data_i[3:0];
            A_LED_SW:  led_sw        <= set_data_i[7:0];
            A_PHY:     phy_reset     <= set_data_i[0];
            A_LED_SRC: led_src       <= set_data_i[7:0];
            default: ;
         endcase
      end
   end

   assign phy_reset_n_o = ~phy_reset;

   ////////////////////
   // LEDs

   // Bit 0 has no hardware source
   assign led_hw = {3'b000, run_tx_i, run_rx_i, clk_status_i, serdes_link_i, 1'b0};

   // Source bit set means hardware owns that LED
   assign leds_o = (led_src & led_hw) | (~led_src & led_sw);

endmodule

// ==== verilog/axil_settings_slave.sv ====
// AXI4-Lite settings slave
// Accepted writes become one-cycle settings strobes, reads return status words

module axil_settings_slave
   import core_pkg::*;
(
   input  logic                  dsp_clk,
   input  logic                  rst_n_i,
   // AXI4-Lite
   input  logic [AXI_ADDR_W-1:0] s_axil_awaddr_i,
   input  logic                  s_axil_awvalid_i,
   output logic                  s_axil_awready_o,
   input  logic [SET_DATA_W-1:0] s_axil_wdata_i,
   input  logic                  s_axil_wvalid_i,
   output logic                  s_axil_wready_o,
   output logic [1:0]            s_axil_bresp_o,
   output logic                  s_axil_bvalid_o,
   input  logic                  s_axil_bready_i,
   input  logic [AXI_ADDR_W-1:0] s_axil_araddr_i,
   input  logic                  s_axil_arvalid_i,
   output logic                  s_axil_arready_o,
   output logic [SET_DATA_W-1:0] s_axil_rdata_o,
   output logic [1:0]            s_axil_rresp_o,
   output logic                  s_axil_rvalid_o,
   input  logic                  s_axil_rready_i,
   // Settings bus
   output logic                  set_stb_o,
   output logic [SET_ADDR_W-1:0] set_addr_o,
   output logic [SET_DATA_W-1:0] set_data_o,
   // Readback sources
   input  logic [NUM_IRQ-1:0]    irq_pend_i,
   input  logic [NUM_IRQ-1:0]    irq_raw_i,
   input  logic [SET_DATA_W-1:0] status_i,
   input  logic [63:0]           time_i,
   input  logic [63:0]           pps_time_i
);

   axil_state_e           wr_state;
   logic                  wr_hs;
   logic                  rd_hs;
   logic                  arready_q;
   logic                  rvalid_q;
   rb_word_e              rd_sel;
   logic [SET_DATA_W-1:0] rd_word;

   ////////////////////
   // Write channel

   // Address and data are taken together, one write in flight
   assign wr_hs            = (wr_state == IDLE) && s_axil_awvalid_i && s_axil_wvalid_i;
   assign s_axil_awready_o = wr_hs;
   assign s_axil_wready_o  = wr_hs;
   assign s_axil_bvalid_o  = (wr_state == RESP);
   assign s_axil_bresp_o   = 2'b00;

   always_ff @(posedge dsp_clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         wr_state  <= IDLE;
         set_stb_o <= 1'b0;
      end else begin
         set_stb_o <= wr_hs;
         case (wr_state)
            IDLE: begin
               if (wr_hs) begin
                  wr_state <= RESP;
               end
            end
            RESP: begin
               if (s_axil_bready_i) begin
                  wr_state <= IDLE;
               end
            end
            default: wr_state <= IDLE;
         endcase
      end
   end

   // Word address of the setting
   always_ff @(posedge dsp_clk) begin
      if (wr_hs) begin
         set_addr_o <= s_axil_awaddr_i[9:2];
         set_data_o <= s_axil_wdata_i;
      end
   end

   ////////////////////
   // Read channel

   assign rd_hs            = s_axil_arvalid_i && arready_q;
   assign s_axil_arready_o = arready_q;
   assign s_axil_rvalid_o  = rvalid_q;
   assign s_axil_rresp_o   = 2'b00;

   always_ff @(posedge dsp_clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         arready_q <= 1'b0;
         rvalid_q  <= 1'b0;
      end else if (rd_hs) begin
         arready_q <= 1'b0;
         rvalid_q  <= 1'b1;
      end else if (rvalid_q && s_axil_rready_i) begin
         arready_q <= 1'b1;
         rvalid_q  <= 1'b0;
      end else if (!rvalid_q) begin
         arready_q <= 1'b1;
      end
   end

   // Readback mux
   assign rd_sel = rb_word_e'(s_axil_araddr_i[5:2]);

   always_comb begin
      case (rd_sel)
         RB_IRQ_PEND: rd_word = {{(SET_DATA_W-NUM_IRQ){1'b0}}, irq_pend_i};
         RB_STATUS:   rd_word = status_i;
         RB_TIME_HI:  rd_word = time_i[63:32];
         RB_TIME_LO:  rd_word = time_i[31:0];
         RB_COMPAT:   rd_word = COMPAT_NUM;
         RB_IRQ_RAW:  rd_word = {{(SET_DATA_W-NUM_IRQ){1'b0}}, irq_raw_i};
         RB_PPS_HI:   rd_word = pps_time_i[63:32];
         RB_PPS_LO:   rd_word = pps_time_i[31:0];
         default:     rd_word = '0;
      endcase
   end

   // Held until the host takes it
   always_ff @(posedge dsp_clk) begin
      if (rd_hs) begin
         s_axil_rdata_o <= rd_word;
      end
   end

   a_bvalid_hold: assert property (@(posedge dsp_clk) disable iff (!rst_n_i)
      s_axil_bvalid_o && !s_axil_bready_i |=> s_axil_bvalid_o);

   a_stb_single: assert property (@(posedge dsp_clk) disable iff (!rst_n_i)
      set_stb_o |=> !set_stb_o);

endmodule

// ==== verilog/core_pkg.sv ====
// Radio core control package
// Settings bus widths, setting register bases and the readback word map

package core_pkg;

   ////////////////////
   // Settings bus

   localparam int SET_ADDR_W = 8;
   localparam int SET_DATA_W = 32;

   // Byte address width of the AXI4-Lite slave
   localparam int AXI_ADDR_W = 12;

   ////////////////////
   // Setting register bases

   // Misc regs use offsets 0 to 4 and 8
   localparam int SR_MISC = 0;

   // Pending high word, then low word with commit
   localparam int SR_TIME64 = 192;

   // Mask, then write-one-to-clear
   localparam int SR_IRQ = 200;

   // Hardware drives LEDs 1 to 4 out of reset
   localparam logic [7:0] LED_SRC_RESET = 8'h1E;

   // Interrupt sources
   localparam int NUM_IRQ = 8;

   // Increment when the register map changes
   localparam logic [SET_DATA_W-1:0] COMPAT_NUM = 32'd5;

   ////////////////////
   // Readback words

   // Indices 0 to 7 are unused and read as zero
   typedef enum logic [3:0] {
      RB_IRQ_PEND = 4'd8,
      RB_STATUS   = 4'd9,
      RB_TIME_HI  = 4'd10,
      RB_TIME_LO  = 4'd11,
      RB_COMPAT   = 4'd12,
      RB_IRQ_RAW  = 4'd13,
      RB_PPS_HI   = 4'd14,
      RB_PPS_LO   = 4'd15
   } rb_word_e;

   // Write channel of the bus slave
   typedef enum logic {
      IDLE,
      RESP
   } axil_state_e;

endpackage
